// File: all.f
+incdir+tb
logic/pluPkg.sv
logic/byteStreamIf.sv
logic/frameControl.sv
logic/wordSerializer.sv
logic/symbolFifo.sv
logic/preambleExtender.sv
logic/wordAssembler.sv
logic/pluLane.sv
tb/tbPluLane.sv

// File: Bender.yml
package:
  name: plu_lane

sources:
  - logic/pluPkg.sv
  - logic/byteStreamIf.sv
  - logic/frameControl.sv
  - logic/wordSerializer.sv
  - logic/symbolFifo.sv
  - logic/preambleExtender.sv
  - logic/wordAssembler.sv
  - logic/pluLane.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tbPluLane.sv

// File: tb/frameTable.svh
/*
  Frame stimulus table
  Each frame has a name, a word count and up to four words. On the lane
  loopback the expected receive words are the sent words in order.
*/
`ifndef FRAME_TABLE_SVH
`define FRAME_TABLE_SVH

localparam int FRAME_CNT = 6;
localparam int MAX_WORDS = 4;
// Four-word frame reused for the overrun run
localparam int OVR_FRAME = 3;

// Columns: name, word count, words 0..3 (unused words are zero)
string frameName [FRAME_CNT] = '{
  "oneWord", "twoWords", "threeWords", "fourWords", "sameBytes", "shortAgain"
};

int frameLen [FRAME_CNT] = '{1, 2, 3, 4, 4, 1};

logic [WORD_W-1:0] frameWords [FRAME_CNT][MAX_WORDS] = '{
  '{32'hA1B2_C3D4, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000},
  '{32'h0102_0304, 32'hF0E0_D0C0, 32'h0000_0000, 32'h0000_0000},
  '{32'hDEAD_BEEF, 32'h5A5A_A5A5, 32'h0F1E_2D3C, 32'h0000_0000},
  '{32'h1122_3344, 32'h5566_7788, 32'h99AA_BBCC, 32'hDDEE_FF00},
  '{32'h7777_7777, 32'h7777_7777, 32'h0000_0000, 32'hFFFF_FFFF},
  '{32'h8000_0001, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000}
};

`endif

// File: tb/tbPluLane.sv
/*
  Frame lane testbench
  Sends table frames through the transmit handshake, checks the lane
  symbols and the looped-back receive words, then forces an overrun
*/
`timescale 1ns/1ps

module tbPluLane;
  import pluPkg::*;

  localparam int HS_TIMEOUT = 200;
  localparam logic [31:0] LFSR_SEED = 32'h4934_9c21;

  `include "frameTable.svh"

  logic              clk;
  logic              reset;
  logic              txReq;
  logic              txLast;
  logic [WORD_W-1:0] txWord;
  logic              txAck;
  logic              laneValid;
  logic              laneSof;
  logic              laneEof;
  logic [BYTE_W-1:0] laneData;
  logic              laneInValid;
  logic              laneInSof;
  logic              laneInEof;
  logic [BYTE_W-1:0] laneInData;
  logic              rxReq;
  logic              rxLast;
  logic              rxOverrun;
  logic [WORD_W-1:0] rxWord;
  logic              rxAck;

  // Lane input source is loopback or the testbench driver
  logic              loopEn;
  logic              drvValid;
  logic              drvSof;
  logic              drvEof;
  logic [BYTE_W-1:0] drvData;

  logic [31:0]       lfsr;
  // Expected lane symbols as {sof, eof, data}
  logic [BYTE_W+1:0] symQ [$];
  logic [BYTE_W+1:0] expSym;
  string             curName;
  logic              prevReq;
  logic              prevAck;
  logic              ackSeen;

  assign laneInValid = loopEn ? laneValid : drvValid;
  assign laneInSof = loopEn ? laneSof : drvSof;
  assign laneInEof = loopEn ? laneEof : drvEof;
  assign laneInData = loopEn ? laneData : drvData;

  pluLane u_pluLane (
    .clk         (clk),
    .reset       (reset),
    .txReq       (txReq),
    .txLast      (txLast),
    .txWord      (txWord),
    .txAck       (txAck),
    .laneValid   (laneValid),
    .laneSof     (laneSof),
    .laneEof     (laneEof),
    .laneData    (laneData),
    .laneInValid (laneInValid),
    .laneInSof   (laneInSof),
    .laneInEof   (laneInEof),
    .laneInData  (laneInData),
    .rxReq       (rxReq),
    .rxLast      (rxLast),
    .rxOverrun   (rxOverrun),
    .rxWord      (rxWord),
    .rxAck       (rxAck)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic failRun(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic checkWord(input string name, input logic [WORD_W-1:0] exp,
                           input logic [WORD_W-1:0] act);
    if (act !== exp)
      failRun($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic checkByte(input string name, input logic [BYTE_W-1:0] exp,
                           input logic [BYTE_W-1:0] act);
    if (act !== exp)
      failRun($sformatf("ERROR %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic checkFlag(input string name, input logic exp, input logic act);
    if (act !== exp)
      failRun($sformatf("ERROR %s: expected %b, actual %b", name, exp, act));
  endtask

  // Fibonacci LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsrBit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic int ackDelay();
    logic [1:0] d;
    d[1] = lfsrBit();
    d[0] = lfsrBit();
    return int'(d);
  endfunction

  task automatic applyReset();
    reset = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic waitTxAck(input logic level);
    int n;
    n = 0;
    while (txAck !== level)
    begin
      @(negedge clk);
      n++;
      if (n > HS_TIMEOUT)
        failRun($sformatf("Timeout: txAck never went to %0b", level));
    end
  endtask

  task automatic waitRxReq(input logic level);
    int n;
    n = 0;
    while (rxReq !== level)
    begin
      @(negedge clk);
      n++;
      if (n > HS_TIMEOUT)
        failRun($sformatf("Timeout: rxReq never went to %0b", level));
    end
  endtask

  task automatic waitOverrun();
    int n;
    n = 0;
    while (rxOverrun !== 1'b1)
    begin
      @(negedge clk);
      n++;
      if (n > HS_TIMEOUT)
        failRun("Timeout: rxOverrun never rose during the unacknowledged frame");
    end
  endtask

  // Lane image of a frame is the sof byte and its repeats followed by the rest
  task automatic appendSymbols(input int f);
    int w;
    int i;
    logic [BYTE_W-1:0] b;
    logic first;
    logic last;
    for (w = 0; w < frameLen[f]; w++)
    begin
      for (i = BYTES_PER_WORD - 1; i >= 0; i--)
      begin
        b = frameWords[f][w][i*BYTE_W +: BYTE_W];
        first = (w == 0) && (i == BYTES_PER_WORD - 1);
        last = (w == frameLen[f] - 1) && (i == 0);
        symQ.push_back({first, last, b});
        if (first)
          repeat (PREAMBLE_LEN - 1) symQ.push_back({1'b0, 1'b0, b});
      end
    end
  endtask

  task automatic sendWord(input int f, input int w);
    txWord = frameWords[f][w];
    txLast = (w == frameLen[f] - 1);
    txReq = 1'b1;
    waitTxAck(1'b1);
    txReq = 1'b0;
    waitTxAck(1'b0);
  endtask

  task automatic takeWord(input int f, input int w);
    string name;
    name = $sformatf("%s word %0d", frameName[f], w);
    waitRxReq(1'b1);
    checkWord(name, frameWords[f][w], rxWord);
    checkFlag({name, " last"}, w == frameLen[f] - 1, rxLast);
    repeat (ackDelay()) @(negedge clk);
    rxAck = 1'b1;
    waitRxReq(1'b0);
    rxAck = 1'b0;
  endtask

  task automatic driveLaneFrame();
    while (symQ.size() > 0)
    begin
      {drvSof, drvEof, drvData} = symQ.pop_front();
      drvValid = 1'b1;
      @(negedge clk);
    end
    drvValid = 1'b0;
    drvSof = 1'b0;
    drvEof = 1'b0;
  endtask

  // Transmit handshake order sampled before the posedge updates
  always @(posedge clk)
  begin
    if (!reset)
    begin
      if (txReq && !prevReq)
        ackSeen = 1'b0;
      if (txAck && !prevAck)
      begin
        if (!prevReq)
          failRun("txAck rose while txReq was low");
        if (ackSeen)
          failRun("txAck rose twice for one txReq");
        ackSeen = 1'b1;
      end
      if (!txAck && prevAck && prevReq)
        failRun("txAck fell while txReq was still high");
    end
    prevReq = txReq;
    prevAck = txAck;
  end

  // Lane monitor
  always @(posedge clk)
  begin
    if (!reset && loopEn && laneValid)
    begin
      if (symQ.size() == 0)
        failRun("Lane symbol seen while no frame was pending");
      else
      begin
        expSym = symQ.pop_front();
        checkFlag({curName, " lane sof"}, expSym[BYTE_W+1], laneSof);
        checkFlag({curName, " lane eof"}, expSym[BYTE_W], laneEof);
        checkByte({curName, " lane data"}, expSym[BYTE_W-1:0], laneData);
      end
    end
  end

  initial
  begin
    int f;
    int w;
    reset = 1'b1;
    txReq = 1'b0;
    txLast = 1'b0;
    txWord = '0;
    rxAck = 1'b0;
    loopEn = 1'b1;
    drvValid = 1'b0;
    drvSof = 1'b0;
    drvEof = 1'b0;
    drvData = '0;
    lfsr = LFSR_SEED;
    curName = "reset";
    prevReq = 1'b0;
    prevAck = 1'b0;
    ackSeen = 1'b0;

    applyReset();
    checkFlag("reset txAck", 1'b0, txAck);
    checkFlag("reset rxReq", 1'b0, rxReq);
    checkFlag("reset laneValid", 1'b0, laneValid);
    checkFlag("reset rxOverrun", 1'b0, rxOverrun);

    // Each word goes out once the previous one is taken since the lane has no back-pressure
    for (f = 0; f < FRAME_CNT; f++)
    begin
      curName = frameName[f];
      appendSymbols(f);
      for (w = 0; w < frameLen[f]; w++)
      begin
        fork
          sendWord(f, w);
          takeWord(f, w);
        join
      end
      if (symQ.size() != 0)
        failRun($sformatf("Lane symbols of frame %s never arrived", curName));
      checkFlag({curName, " rxOverrun"}, 1'b0, rxOverrun);
    end

    // Overrun with the lane driven directly and rxAck held low
    curName = "overrun";
    loopEn = 1'b0;
    appendSymbols(OVR_FRAME);
    driveLaneFrame();
    waitOverrun();
    repeat (4)
    begin
      @(negedge clk);
      checkFlag("overrun hold", 1'b1, rxOverrun);
    end
    applyReset();
    checkFlag("overrun after reset", 1'b0, rxOverrun);

    $display("All tests passed");
    $finish;
  end

endmodule

// File: logic/pluLane.sv
/*
  Physical layer frame lane
  Transmit path from req/ack words to stretched lane bytes, receive
  path from lane bytes back to req/ack words
*/
`timescale 1ns/1ps

module pluLane (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      txReq,
  input  logic                      txLast,
  input  logic [pluPkg::WORD_W-1:0] txWord,
  output logic                      txAck,
  output logic                      laneValid,
  output logic                      laneSof,
  output logic                      laneEof,
  output logic [pluPkg::BYTE_W-1:0] laneData,
  input  logic                      laneInValid,
  input  logic                      laneInSof,
  input  logic                      laneInEof,
  input  logic [pluPkg::BYTE_W-1:0] laneInData,
  output logic                      rxReq,
  output logic                      rxLast,
  output logic                      rxOverrun,
  output logic [pluPkg::WORD_W-1:0] rxWord,
  input  logic                      rxAck
);
  import pluPkg::*;

  logic              load;
  logic              loadLast;
  logic [WORD_W-1:0] loadWord;
  logic              serIdle;
  logic              wordDone;
  logic              doneLast;
  logic [WORD_W-1:0] doneWord;

  byteStreamIf serStream ();

  frameControl u_frameControl (
    .clk       (clk),
    .reset     (reset),
    .txReq     (txReq),
    .txLast    (txLast),
    .txWord    (txWord),
    .txAck     (txAck),
    .serIdle   (serIdle),
    .load      (load),
    .loadLast  (loadLast),
    .loadWord  (loadWord),
    .wordDone  (wordDone),
    .doneLast  (doneLast),
    .doneWord  (doneWord),
    .rxAck     (rxAck),
    .rxReq     (rxReq),
    .rxLast    (rxLast),
    .rxOverrun (rxOverrun),
    .rxWord    (rxWord)
  );

  // Transmit datapath
  wordSerializer u_wordSerializer (
    .clk      (clk),
    .reset    (reset),
    .load     (load),
    .loadLast (loadLast),
    .loadWord (loadWord),
    .serIdle  (serIdle),
    .out      (serStream.src)
  );

  preambleExtender u_preambleExtender (
    .clk       (clk),
    .reset     (reset),
    .in        (serStream.dst),
    .laneValid (laneValid),
    .laneSof   (laneSof),
    .laneEof   (laneEof),
    .laneData  (laneData)
  );

  // Receive datapath
  wordAssembler u_wordAssembler (
    .clk         (clk),
    .reset       (reset),
    .laneInValid (laneInValid),
    .laneInSof   (laneInSof),
    .laneInEof   (laneInEof),
    .laneInData  (laneInData),
    .wordDone    (wordDone),
    .doneLast    (doneLast),
    .doneWord    (doneWord)
  );

endmodule

// File: logic/wordAssembler.sv
/*
  Word assembler
  Drops the repeated frame-start copies from the lane and packs the
  remaining bytes into words, most significant first
*/
`timescale 1ns/1ps

module wordAssembler (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      laneInValid,
  input  logic                      laneInSof,
  input  logic                      laneInEof,
  input  logic [pluPkg::BYTE_W-1:0] laneInData,
  output logic                      wordDone,
  output logic                      doneLast,
  output logic [pluPkg::WORD_W-1:0] doneWord
);
  import pluPkg::*;

  logic [WORD_W-1:0]         shiftReg;
  logic [PREAMBLE_CNT_W-1:0] skipCnt;
  logic [BYTE_IDX_W-1:0]     byteIdx;
  logic                      inFrame;
  logic                      takeByte;

  // The sof copy is data byte 3, the repeats after it are skipped
  assign takeByte = laneInValid && (laneInSof || (inFrame && (skipCnt == '0)));
  assign doneWord = shiftReg;

  always_ff @(posedge clk)
  begin
    if (takeByte)
      shiftReg <= {shiftReg[WORD_W-BYTE_W-1:0], laneInData};
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      inFrame <= 1'b0;
      skipCnt <= '0;
      byteIdx <= '0;
      wordDone <= 1'b0;
      doneLast <= 1'b0;
    end
    else
    begin
      wordDone <= 1'b0;
      if (laneInValid && laneInSof)
      begin
        inFrame <= 1'b1;
        skipCnt <= PREAMBLE_CNT_W'(PREAMBLE_LEN - 1);
        byteIdx <= BYTE_IDX_W'(1);
      end
      else if (laneInValid && inFrame && (skipCnt != '0))
      begin
        skipCnt <= skipCnt - 1'b1;
      end
      else if (takeByte)
      begin
        byteIdx <= byteIdx + 1'b1;
        if (byteIdx == BYTE_IDX_W'(BYTES_PER_WORD - 1))
        begin
          wordDone <= 1'b1;
          doneLast <= laneInEof;
          // Frame closed, ignore lane until the next sof
          if (laneInEof)
            inFrame <= 1'b0;
        end
      end
    end
  end

endmodule

// File: logic/preambleExtender.sv
/*
  Preamble extender
  Buffers serializer bytes and stretches each frame start so the first
  byte goes out PREAMBLE_LEN times, sof on the first copy only
*/
`timescale 1ns/1ps

module preambleExtender (
  input  logic                      clk,
  input  logic                      reset,
  byteStreamIf.dst                  in,
  output logic                      laneValid,
  output logic                      laneSof,
  output logic                      laneEof,
  output logic [pluPkg::BYTE_W-1:0] laneData
);
  import pluPkg::*;

  logic [BYTE_W-1:0]         headData;
  logic                      headSof;
  logic                      headEof;
  logic                      empty;
  logic                      pop;
  // Copies of the current sof head already sent
  logic [PREAMBLE_CNT_W-1:0] repCnt;
  logic                      lastCopy;

  symbolFifo u_symbolFifo (
    .clk      (clk),
    .reset    (reset),
    .push     (in.valid),
    .pushData (in.data),
    .pushSof  (in.sof),
    .pushEof  (in.eof),
    .pop      (pop),
    .headData (headData),
    .headSof  (headSof),
    .headEof  (headEof),
    .empty    (empty)
  );

  assign lastCopy = (repCnt == PREAMBLE_CNT_W'(PREAMBLE_LEN - 1));

  // A sof head stays in place until its last copy goes out
  assign pop = !empty && (!headSof || lastCopy);

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      laneValid <= 1'b0;
      laneSof <= 1'b0;
      laneEof <= 1'b0;
      repCnt <= '0;
    end
    else
    begin
      laneValid <= !empty;
      laneSof <= !empty && headSof && (repCnt == '0);
      laneEof <= pop && headEof;
      if (!empty && headSof)
        repCnt <= lastCopy ? '0 : repCnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!empty)
      laneData <= headData;
  end

endmodule

// File: logic/symbolFifo.sv
/*
  Symbol FIFO
  Synchronous FIFO of lane bytes with their sof/eof markers,
  head visible combinationally
*/
`timescale 1ns/1ps

module symbolFifo #(
  parameter int DEPTH = pluPkg::FIFO_DEPTH,
  parameter int CNT_W = pluPkg::FIFO_CNT_W
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      push,
  input  logic [pluPkg::BYTE_W-1:0] pushData,
  input  logic                      pushSof,
  input  logic                      pushEof,
  input  logic                      pop,
  output logic [pluPkg::BYTE_W-1:0] headData,
  output logic                      headSof,
  output logic                      headEof,
  output logic                      empty
);
  import pluPkg::*;

  // Entry layout is {sof, eof, data}
  logic [BYTE_W+1:0] mem [DEPTH];
  logic [CNT_W-2:0]  wrPtr;
  logic [CNT_W-2:0]  rdPtr;
  logic [CNT_W-1:0]  count;
  logic              doPush;
  logic              doPop;

  assign empty = (count == '0);
  assign doPush = push && (count != CNT_W'(DEPTH));
  assign doPop = pop && !empty;
  assign {headSof, headEof, headData} = mem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (doPush)
      mem[wrPtr] <= {pushSof, pushEof, pushData};
  end

  // Pointers wrap on their own since DEPTH is a power of two
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doPush)
        wrPtr <= wrPtr + 1'b1;
      if (doPop)
        rdPtr <= rdPtr + 1'b1;
      count <= count + CNT_W'(doPush) - CNT_W'(doPop);
    end
  end

endmodule

// File: logic/wordSerializer.sv
/*
  Word serializer
  Sends a loaded word as bytes, most significant first, one per cycle,
  with sof on the first byte of a frame and eof on the last
*/
`timescale 1ns/1ps

module wordSerializer (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      load,
  input  logic                      loadLast,
  input  logic [pluPkg::WORD_W-1:0] loadWord,
  output logic                      serIdle,
  byteStreamIf.src                  out
);
  import pluPkg::*;

  logic [WORD_W-1:0]     shiftReg;
  logic [BYTE_IDX_W-1:0] byteIdx;
  logic                  busy;
  logic                  lastWord;
  // Next byte 0 opens a new frame
  logic                  frameStart;
  logic                  lastByte;

  assign lastByte = (byteIdx == BYTE_IDX_W'(BYTES_PER_WORD - 1));
  assign serIdle = !busy;

  assign out.valid = busy;
  assign out.data = shiftReg[WORD_W-1 -: BYTE_W];
  assign out.sof = busy && frameStart && (byteIdx == '0);
  assign out.eof = busy && lastWord && lastByte;

  always_ff @(posedge clk)
  begin
    if (load)
      shiftReg <= loadWord;
    else if (busy)
      shiftReg <= shiftReg << BYTE_W;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      busy <= 1'b0;
      byteIdx <= '0;
      lastWord <= 1'b0;
      frameStart <= 1'b1;
    end
    else if (load)
    begin
      busy <= 1'b1;
      byteIdx <= '0;
      lastWord <= loadLast;
    end
    else if (busy)
    begin
      byteIdx <= byteIdx + 1'b1;
      if (byteIdx == '0)
        frameStart <= 1'b0;
      if (lastByte)
      begin
        busy <= 1'b0;
        frameStart <= lastWord;
      end
    end
  end

endmodule

// File: logic/frameControl.sv
/*
  Frame control
  Transmit and receive four-phase req/ack FSMs, receive word register
  and the sticky overrun flag
*/
`timescale 1ns/1ps

module frameControl (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      txReq,
  input  logic                      txLast,
  input  logic [pluPkg::WORD_W-1:0] txWord,
  output logic                      txAck,
  input  logic                      serIdle,
  output logic                      load,
  output logic                      loadLast,
  output logic [pluPkg::WORD_W-1:0] loadWord,
  input  logic                      wordDone,
  input  logic                      doneLast,
  input  logic [pluPkg::WORD_W-1:0] doneWord,
  input  logic                      rxAck,
  output logic                      rxReq,
  output logic                      rxLast,
  output logic                      rxOverrun,
  output logic [pluPkg::WORD_W-1:0] rxWord
);
  import pluPkg::*;

  logic [HS_STATE_W-1:0] txState;
  logic [HS_STATE_W-1:0] rxState;
  logic                  rxCapture;

  // Source holds word and last flag stable while txReq is up
  assign loadWord = txWord;
  assign loadLast = txLast;
  assign load = (txState == HS_LOAD);
  assign txAck = (txState == HS_ACK);

  assign rxReq = (rxState == HS_ACK);
  assign rxCapture = wordDone && (rxState == HS_IDLE);

  // Transmit side: wait for req and an idle serializer, load, ack, release
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      txState <= HS_IDLE;
    end
    else
    begin
      case (txState)
        HS_IDLE:    if (txReq && serIdle) txState <= HS_LOAD;
        HS_LOAD:    txState <= HS_ACK;
        HS_ACK:     if (!txReq) txState <= HS_RELEASE;
        HS_RELEASE: txState <= HS_IDLE;
        default:    txState <= HS_IDLE;
      endcase
    end
  end

  // Receive side, LOAD gives the word one cycle of setup before rxReq
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      rxState <= HS_IDLE;
      rxOverrun <= 1'b0;
    end
    else
    begin
      case (rxState)
        HS_IDLE:    if (wordDone) rxState <= HS_LOAD;
        HS_LOAD:    rxState <= HS_ACK;
        HS_ACK:     if (rxAck) rxState <= HS_RELEASE;
        HS_RELEASE: if (!rxAck) rxState <= HS_IDLE;
        default:    rxState <= HS_IDLE;
      endcase
      // Word completed while the sink still owns the previous one
      if (wordDone && (rxState != HS_IDLE))
        rxOverrun <= 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rxCapture)
    begin
      rxWord <= doneWord;
      rxLast <= doneLast;
    end
  end

endmodule

// File: logic/byteStreamIf.sv
/*
  Byte stream interface
  One lane symbol per cycle while valid is high, no back-pressure
*/
`timescale 1ns/1ps

interface byteStreamIf #(
  parameter int DATA_W = pluPkg::BYTE_W
);

  logic              valid;
  logic [DATA_W-1:0] data;
  // Frame markers, only meaningful with valid
  logic              sof;
  logic              eof;

  modport src (output valid, output data, output sof, output eof);

  modport dst (input valid, input data, input sof, input eof);

endinterface

// File: logic/pluPkg.sv
/*
  Frame lane package
  Lane and word widths, preamble stretch length, extender FIFO sizing
  and the state codes shared by the handshake FSMs
*/
package pluPkg;

  // Lane symbol and transfer word
  localparam int BYTE_W = 8;
  localparam int WORD_W = 32;
  localparam int BYTES_PER_WORD = 4;
  localparam int BYTE_IDX_W = 2;

  // Number of copies of the first frame byte on the lane
  localparam int PREAMBLE_LEN = 8;
  localparam int PREAMBLE_CNT_W = 3;

  // Extender FIFO
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_CNT_W = 5;

  // Four-phase handshake FSM states
  localparam int HS_STATE_W = 2;
  localparam logic [HS_STATE_W-1:0] HS_IDLE = 2'd0;
  localparam logic [HS_STATE_W-1:0] HS_LOAD = 2'd1;
  localparam logic [HS_STATE_W-1:0] HS_ACK = 2'd2;
  localparam logic [HS_STATE_W-1:0] HS_RELEASE = 2'd3;

endpackage
